/* all.f */
hdl/ibi_pkg.sv
hdl/ibi_descriptor_unpack.sv
hdl/ibi_byte_fifo.sv
hdl/ibi_bus_tx.sv
hdl/ibi_tx_path.sv
verification/ibi_tx_path_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ibi_tx_path_tb
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Run from the project root so the pattern file is found
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* verification/ibi_patterns.txt */
# W <hex word>: next IBI queue word, each descriptor followed by its data words
# E <hex byte> <T-bit>: next byte expected on SDA and the T-bit sent after it
# One byte, upper descriptor bits set but ignored
W 5A5A0001
W DEADBEA5
E a5 0
# Six bytes, two pad bytes dropped
W 00000006
W 44332211
W CCBB6655
E 11 1
E 22 1
E 33 1
E 44 1
E 55 1
E 66 0
# Nine bytes, queued while SCL is held
W 00000009
W 0F1E2D3C
W 4B5A6978
W 8796A5B4
E 3c 1
E 2d 1
E 1e 1
E 0f 1
E 78 1
E 69 1
E 5a 1
E 4b 1
E b4 0
W 00000001
W 000000FF
E ff 0

/* verification/ibi_tx_path_tb.sv */
// Reads verification/ibi_patterns.txt, so the simulator must start in the project root
`timescale 1ns/1ns

module ibi_tx_path_tb
  import ibi_pkg::*;
();

  localparam int unsigned FifoDepth = 4;
  localparam int DriveDelay  = 2;
  localparam int StallCycles = 20;
  localparam int WordTimeout = 5000;
  localparam int PauseLimit  = 2000;
  localparam int DrainLimit  = 40000;

  logic        clk_i;
  logic        rst_ni;
  logic        ibi_queue_rvalid_i;
  queue_word_t ibi_queue_rdata_i;
  logic        ibi_queue_rready_o;
  logic        scl_negedge_i;
  logic        scl_posedge_i;
  timing_t     t_hd_dat_i;
  logic        sda_o;
  logic        sel_od_pp_o;
  logic        ibi_done_o;

  queue_word_t words_q[$];
  // Entries are {T-bit, byte}
  logic [8:0]  expect_q[$];
  logic [8:0]  bits;
  logic [31:0] gap_rng;
  int exp_total, ibi_total, nbits, bytes_seen, done_count, final_tbits;
  int value_errors, other_errors;
  logic timed_out, pause_req, scl_held, stall_seen, monitor_on, prev_negedge, prev_done;

  ibi_tx_path #(
    .FifoDepth (FifoDepth)
  ) dut_i (
    .clk_i,
    .rst_ni,
    .ibi_queue_rvalid_i,
    .ibi_queue_rdata_i,
    .ibi_queue_rready_o,
    .scl_negedge_i,
    .scl_posedge_i,
    .t_hd_dat_i,
    .sda_o,
    .sel_od_pp_o,
    .ibi_done_o
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #DriveDelay;
    end
  endtask

  task automatic expect_level(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, want);
      value_errors++;
    end
  endtask

  task automatic load_patterns();
    int fd;
    string line;
    logic [31:0] word;
    logic [7:0] data;
    logic [7:0] tbit;
    int left;
    fd = $fopen("verification/ibi_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file verification/ibi_patterns.txt");
      other_errors++;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) > 0) begin
          if ($sscanf(line, "W %h", word) == 1) begin
            words_q.push_back(word);
          end else if ($sscanf(line, "E %h %h", data, tbit) == 2) begin
            expect_q.push_back({tbit[0], data});
          end
        end
      end
      $fclose(fd);
    end
    exp_total = expect_q.size();
    // A descriptor with count N is followed by ceil(N/4) data words
    left = 0;
    foreach (words_q[i]) begin
      if (left == 0) begin
        ibi_total++;
        left = (int'(words_q[i][7:0]) + 3) / 4;
      end else begin
        left--;
      end
    end
  endtask

  task automatic send_word(input queue_word_t word);
    int waited;
    int held_waited;
    logic accepted;
    gap_rng = xorshift32(gap_rng);
    next_cycles(int'(gap_rng[2:0]));
    ibi_queue_rvalid_i = 1'b1;
    ibi_queue_rdata_i  = word;
    waited      = 0;
    held_waited = 0;
    accepted    = 1'b0;
    while (!accepted && !timed_out) begin
      @(negedge clk_i);
      if (ibi_queue_rready_o) begin
        accepted = 1'b1;
      end else begin
        waited++;
        // Held SCL has backed the path up to the queue
        if (pause_req && scl_held) begin
          held_waited++;
          if (held_waited >= StallCycles) begin
            stall_seen = 1'b1;
            pause_req  = 1'b0;
          end
        end
        if (waited > WordTimeout) begin
          $display("Timeout: queue word %h not taken after %0d cycles", word, waited);
          other_errors++;
          timed_out = 1'b1;
        end
      end
      @(posedge clk_i);
      #DriveDelay;
    end
    ibi_queue_rvalid_i = 1'b0;
  endtask

  task automatic feed_queue();
    int left;
    left = 0;
    foreach (words_q[i]) begin
      if (!timed_out) begin
        if (left == 0) begin
          left = (int'(words_q[i][7:0]) + 3) / 4;
          if (int'(words_q[i][7:0]) > 2 * FifoDepth) begin
            pause_req = 1'b1;
          end
        end else begin
          left--;
        end
        send_word(words_q[i]);
        if (left == 0) begin
          pause_req = 1'b0;
        end
      end
    end
  endtask

  task automatic check_byte(input logic [8:0] got);
    logic [8:0] want;
    if (expect_q.size() == 0) begin
      $display("Byte 0x%h appeared on SDA after the last expected byte", got[8:1]);
      other_errors++;
    end else begin
      want = expect_q.pop_front();
      if (got[8:1] !== want[7:0]) begin
        $display("** Error: sda_o byte %0d = 0x%h, expected 0x%h", bytes_seen, got[8:1],
                 want[7:0]);
        value_errors++;
      end
      if (got[0] !== want[8]) begin
        $display("** Error: sda_o T-bit of byte %0d = 0x%h, expected 0x%h", bytes_seen,
                 got[0], want[8]);
        value_errors++;
      end
    end
    if (got[0] == 1'b0) begin
      final_tbits++;
    end
    bytes_seen++;
  endtask

  task automatic sample_bit();
    if (sel_od_pp_o === 1'b1) begin
      bits = {bits[7:0], sda_o};
      nbits++;
      if (nbits == 9) begin
        check_byte(bits);
        nbits = 0;
      end
    end else begin
      if (nbits != 0) begin
        expect_level("sel_od_pp_o", sel_od_pp_o, 1'b1);
      end
      expect_level("sda_o", sda_o, 1'b1);
    end
  endtask

  task automatic check_done();
    if (prev_done) begin
      $display("ibi_done_o stayed high for more than one cycle");
      other_errors++;
    end
    if (!prev_negedge) begin
      $display("ibi_done_o did not come one cycle after an SCL falling strobe");
      other_errors++;
    end
    expect_level("sda_o", sda_o, 1'b1);
    expect_level("sel_od_pp_o", sel_od_pp_o, 1'b0);
    done_count++;
    if (done_count != final_tbits) begin
      $display("ibi_done_o pulse %0d came without a matching final byte", done_count);
      other_errors++;
    end
  endtask

  // Bus monitor, sampled mid-cycle
  always @(negedge clk_i) begin
    if (monitor_on) begin
      if (ibi_done_o) begin
        check_done();
      end
      if (scl_posedge_i) begin
        sample_bit();
      end
      prev_negedge = scl_negedge_i;
      prev_done    = ibi_done_o;
    end
  end

  // SCL strobes, 10 cycles apart
  initial begin
    logic [31:0] scl_rng;
    int waited;
    scl_rng = xorshift32(32'd62);
    next_cycles(20);
    forever begin
      scl_rng = xorshift32(scl_rng);
      if (scl_rng[3:0] == 4'd0) begin
        next_cycles(int'(scl_rng[9:4]));
      end
      waited = 0;
      while (pause_req && !timed_out) begin
        scl_held = 1'b1;
        next_cycles(1);
        waited++;
        if (waited > PauseLimit) begin
          $display("Timeout: SCL held for %0d cycles without a queue stall", waited);
          other_errors++;
          timed_out = 1'b1;
        end
      end
      scl_held = 1'b0;
      scl_negedge_i = 1'b1;
      next_cycles(1);
      scl_negedge_i = 1'b0;
      next_cycles(9);
      scl_posedge_i = 1'b1;
      next_cycles(1);
      scl_posedge_i = 1'b0;
      next_cycles(9);
    end
  end

  initial begin
    int waited;
    rst_ni             = 1'b0;
    ibi_queue_rvalid_i = 1'b0;
    ibi_queue_rdata_i  = '0;
    scl_negedge_i      = 1'b0;
    scl_posedge_i      = 1'b0;
    t_hd_dat_i         = timing_t'(3);
    timed_out    = 1'b0;
    pause_req    = 1'b0;
    scl_held     = 1'b0;
    stall_seen   = 1'b0;
    monitor_on   = 1'b0;
    prev_negedge = 1'b0;
    prev_done    = 1'b0;
    exp_total    = 0;
    ibi_total    = 0;
    nbits        = 0;
    bytes_seen   = 0;
    done_count   = 0;
    final_tbits  = 0;
    value_errors = 0;
    other_errors = 0;
    bits         = '0;
    gap_rng      = 32'd62;
    load_patterns();
    next_cycles(16);
    rst_ni = 1'b1;
    next_cycles(1);
    expect_level("sda_o", sda_o, 1'b1);
    expect_level("sel_od_pp_o", sel_od_pp_o, 1'b0);
    expect_level("ibi_queue_rready_o", ibi_queue_rready_o, 1'b1);
    expect_level("ibi_done_o", ibi_done_o, 1'b0);
    monitor_on = 1'b1;
    feed_queue();
    waited = 0;
    while (!timed_out && (bytes_seen < exp_total || done_count < ibi_total)) begin
      next_cycles(1);
      waited++;
      if (waited > DrainLimit) begin
        $display("Timeout: %0d of %0d bytes seen on SDA", bytes_seen, exp_total);
        other_errors++;
        timed_out = 1'b1;
      end
    end
    next_cycles(40);
    expect_level("sda_o", sda_o, 1'b1);
    expect_level("sel_od_pp_o", sel_od_pp_o, 1'b0);
    if (done_count != ibi_total) begin
      $display("** Error: ibi_done_o pulses = 0x%h, expected 0x%h", done_count, ibi_total);
      value_errors++;
    end
    if (!stall_seen) begin
      $display("ibi_queue_rready_o never went low while SCL was held");
      other_errors++;
    end
    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* hdl/ibi_tx_path.sv */
// IBI transmit path from queue to SDA; no arbitration or address phase, bus edges come from outside
`timescale 1ns/1ns

module ibi_tx_path
  import ibi_pkg::*;
#(
  parameter int unsigned FifoDepth = 4
) (
  input  logic        clk_i,
  input  logic        rst_ni,

  input  logic        ibi_queue_rvalid_i,
  input  queue_word_t ibi_queue_rdata_i,
  output logic        ibi_queue_rready_o,

  input  logic        scl_negedge_i,
  input  logic        scl_posedge_i,
  input  timing_t     t_hd_dat_i,

  output logic        sda_o,
  output logic        sel_od_pp_o,
  output logic        ibi_done_o
);

  logic      push_valid;
  bus_byte_t push_byte;
  logic      push_last;
  logic      push_ready;

  logic      pop_valid;
  bus_byte_t pop_byte;
  logic      pop_last;
  logic      pop_ready;

  ibi_descriptor_unpack u_unpack (
    .clk_i,
    .rst_ni,
    .ibi_queue_rvalid_i,
    .ibi_queue_rdata_i,
    .ibi_queue_rready_o,
    .byte_valid_o (push_valid),
    .byte_o       (push_byte),
    .byte_last_o  (push_last),
    .byte_ready_i (push_ready)
  );

  ibi_byte_fifo #(
    .FifoDepth (FifoDepth)
  ) u_fifo (
    .clk_i,
    .rst_ni,
    .push_valid_i (push_valid),
    .push_byte_i  (push_byte),
    .push_last_i  (push_last),
    .push_ready_o (push_ready),
    .pop_valid_o  (pop_valid),
    .pop_byte_o   (pop_byte),
    .pop_last_o   (pop_last),
    .pop_ready_i  (pop_ready)
  );

  ibi_bus_tx u_bus_tx (
    .clk_i,
    .rst_ni,
    .scl_negedge_i,
    .scl_posedge_i,
    .t_hd_dat_i,
    .byte_valid_i (pop_valid),
    .byte_i       (pop_byte),
    .byte_last_i  (pop_last),
    .byte_ready_o (pop_ready),
    .sda_o,
    .sel_od_pp_o,
    .ibi_done_o
  );

endmodule

/* hdl/ibi_bus_tx.sv */
// Shifts IBI bytes and T-bits onto SDA; t_hd_dat_i must be at least 1 and shorter than SCL low
`timescale 1ns/1ns

module ibi_bus_tx
  import ibi_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  // SCL edge strobes and hold time
  input  logic      scl_negedge_i,
  input  logic      scl_posedge_i,
  input  timing_t   t_hd_dat_i,

  // Byte stream from the buffer
  input  logic      byte_valid_i,
  input  bus_byte_t byte_i,
  input  logic      byte_last_i,
  output logic      byte_ready_o,

  // Bus side
  output logic      sda_o,
  output logic      sel_od_pp_o,
  output logic      ibi_done_o
);

  tx_state_e  state_q;
  bus_byte_t  shift_q;
  logic [3:0] bit_cnt_q;
  timing_t    hold_cnt_q;
  logic       last_q;
  logic       sda_q;
  logic       sel_od_pp_q;
  logic       done_q;

  logic byte_fire;
  logic hold_expired;

  // New bytes are taken only when SCL falls at a byte boundary
  assign byte_ready_o = scl_negedge_i &&
                        ((state_q == TxIdle) || (state_q == TxTbit && !last_q));
  assign byte_fire    = byte_valid_i & byte_ready_o;
  assign hold_expired = (state_q == TxHold) && (hold_cnt_q == timing_t'(1));

  assign sda_o       = sda_q;
  assign sel_od_pp_o = sel_od_pp_q;
  assign ibi_done_o  = done_q;

  always_ff @(posedge clk_i) begin
    if (byte_fire) begin
      shift_q <= byte_i;
    end else if (hold_expired && bit_cnt_q != 4'd8) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= TxIdle;
      bit_cnt_q   <= '0;
      hold_cnt_q  <= '0;
      last_q      <= 1'b0;
      sda_q       <= 1'b1;
      sel_od_pp_q <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (byte_fire) begin
        last_q     <= byte_last_i;
        bit_cnt_q  <= '0;
        hold_cnt_q <= t_hd_dat_i;
        state_q    <= TxHold;
      end else begin
        unique case (state_q)
          TxIdle: ;
          TxHold: begin
            if (hold_expired) begin
              sel_od_pp_q <= 1'b1;
              if (bit_cnt_q == 4'd8) begin
                // T-bit high means more data follows
                sda_q   <= ~last_q;
                state_q <= TxTbit;
              end else begin
                sda_q   <= shift_q[7];
                state_q <= TxBit;
              end
            end else begin
              hold_cnt_q <= hold_cnt_q - timing_t'(1);
            end
          end
          TxBit: begin
            // Bit counts once the controller has sampled it
            if (scl_posedge_i) begin
              bit_cnt_q <= bit_cnt_q + 4'd1;
            end
            if (scl_negedge_i) begin
              hold_cnt_q <= t_hd_dat_i;
              state_q    <= TxHold;
            end
          end
          TxTbit: begin
            if (scl_negedge_i) begin
              sda_q       <= 1'b1;
              sel_od_pp_q <= 1'b0;
              done_q      <= last_q;
              state_q     <= TxIdle;
            end
          end
          default: state_q <= TxIdle;
        endcase
      end
    end
  end

  // SDA settles before SCL rises
  a_sda_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    scl_posedge_i |-> $stable(sda_o))
    else $error("SDA changed on SCL rising edge");

endmodule

/* hdl/ibi_byte_fifo.sv */
// Byte buffer with last flags; FifoDepth must be a power of two, at least 2
`timescale 1ns/1ns

module ibi_byte_fifo
  import ibi_pkg::*;
#(
  parameter int unsigned FifoDepth = 4
) (
  input  logic      clk_i,
  input  logic      rst_ni,

  input  logic      push_valid_i,
  input  bus_byte_t push_byte_i,
  input  logic      push_last_i,
  output logic      push_ready_o,

  output logic      pop_valid_o,
  output bus_byte_t pop_byte_o,
  output logic      pop_last_o,
  input  logic      pop_ready_i
);

  localparam int unsigned PtrWidth   = $clog2(FifoDepth);
  localparam int unsigned CountWidth = $clog2(FifoDepth + 1);

  // Each entry is {last, byte}
  logic [8:0]            mem_q [FifoDepth];
  logic [PtrWidth-1:0]   wr_ptr_q;
  logic [PtrWidth-1:0]   rd_ptr_q;
  logic [CountWidth-1:0] count_q;

  logic push_fire;
  logic pop_fire;

  assign push_ready_o = (count_q != CountWidth'(FifoDepth));
  assign pop_valid_o  = (count_q != '0);
  assign push_fire    = push_valid_i & push_ready_o;
  assign pop_fire     = pop_valid_o & pop_ready_i;

  assign {pop_last_o, pop_byte_o} = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      mem_q[wr_ptr_q] <= {push_last_i, push_byte_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push_fire && !pop_fire) begin
        count_q <= count_q + 1'b1;
      end else if (pop_fire && !push_fire) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Producer keeps its byte while the buffer is full
  a_push_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (push_valid_i && !push_ready_o) |=>
      (push_valid_i && $stable(push_byte_i) && $stable(push_last_i)))
    else $error("byte dropped while buffer full");

endmodule

/* hdl/ibi_descriptor_unpack.sv */
// Splits IBI queue words into bytes, low byte first; a descriptor count of zero is not supported
`timescale 1ns/1ns

module ibi_descriptor_unpack
  import ibi_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  // IBI queue
  input  logic        ibi_queue_rvalid_i,
  input  queue_word_t ibi_queue_rdata_i,
  output logic        ibi_queue_rready_o,

  // Byte stream
  output logic        byte_valid_o,
  output bus_byte_t   byte_o,
  output logic        byte_last_o,
  input  logic        byte_ready_i
);

  unpack_state_e state_q;
  queue_word_t   word_q;
  logic [1:0]    byte_idx_q;
  byte_count_t   remaining_q;

  logic word_fire;
  logic byte_fire;
  logic word_end;

  // Last byte of the held word, with more data words still to come
  assign word_end = (byte_idx_q == 2'd3) && (remaining_q != byte_count_t'(1));

  // Next word can replace the held one as its final byte leaves
  always_comb begin
    unique case (state_q)
      UnpackBytes: ibi_queue_rready_o = byte_ready_i & word_end;
      default:     ibi_queue_rready_o = 1'b1;
    endcase
  end

  assign word_fire = ibi_queue_rvalid_i & ibi_queue_rready_o;

  assign byte_valid_o = (state_q == UnpackBytes);
  assign byte_o       = word_q[{byte_idx_q, 3'b000} +: 8];
  assign byte_last_o  = (remaining_q == byte_count_t'(1));
  assign byte_fire    = byte_valid_o & byte_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= UnpackDesc;
      byte_idx_q  <= '0;
      remaining_q <= '0;
    end else begin
      unique case (state_q)
        UnpackDesc: begin
          if (word_fire) begin
            remaining_q <= ibi_queue_rdata_i[7:0];
            state_q     <= UnpackWord;
          end
        end
        UnpackWord: begin
          if (word_fire) begin
            byte_idx_q <= '0;
            state_q    <= UnpackBytes;
          end
        end
        UnpackBytes: begin
          if (byte_fire) begin
            remaining_q <= remaining_q - byte_count_t'(1);
            if (byte_last_o) begin
              byte_idx_q <= '0;
              state_q    <= UnpackDesc;
            end else if (byte_idx_q == 2'd3) begin
              byte_idx_q <= '0;
              if (!word_fire) begin
                state_q <= UnpackWord;
              end
            end else begin
              byte_idx_q <= byte_idx_q + 2'd1;
            end
          end
        end
        default: state_q <= UnpackDesc;
      endcase
    end
  end

  // Data word holding register
  always_ff @(posedge clk_i) begin
    if (word_fire && state_q != UnpackDesc) begin
      word_q <= ibi_queue_rdata_i;
    end
  end

  // Queue writer must never post an empty IBI
  a_nonzero_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == UnpackDesc && ibi_queue_rvalid_i) |-> (ibi_queue_rdata_i[7:0] != '0))
    else $error("IBI descriptor with zero byte count");

endmodule

/* hdl/ibi_pkg.sv */
// Types shared by the IBI transmit path; byte counts are 1 to 255, hold times are in clock cycles
package ibi_pkg;

  // One word read from the IBI queue
  typedef logic [31:0] queue_word_t;

  // One byte as it goes out on SDA
  typedef logic [7:0] bus_byte_t;

  // Data byte count carried in the low byte of a descriptor
  typedef logic [7:0] byte_count_t;

  // SDA hold time after SCL falls, in clock cycles
  typedef logic [19:0] timing_t;

  // Descriptor unpacker
  typedef enum logic [1:0] {
    UnpackDesc,
    UnpackWord,
    UnpackBytes
  } unpack_state_e;

  // Bus transmitter
  typedef enum logic [1:0] {
    TxIdle,
    TxHold,
    TxBit,
    TxTbit
  } tx_state_e;

endpackage
